// File: build.f
+incdir+hw
hw/rv_decode_pkg.sv
hw/decode_if.sv
hw/imm_bus_if.sv
hw/id_stage_reg.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/id_issue.sv
hw/id_stage.sv
tb/tb_id_stage.sv

// File: Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --assert -f build.f --top-module tb_id_stage -o sim_id_stage
	./obj_dir/sim_id_stage | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tb/tb_id_stage.sv
// tb_id_stage testbench, clock and reset, random stimulus, reference decoder, compare tasks
`timescale 1ns/1ps
`include "rv_defines.svh"

module tb_id_stage;
    import rv_decode_pkg::*;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic                 wen;
        logic                 needs_rs1;
        logic                 needs_rs2;
        logic [`XLEN-1:0]     imm; // after imm_sel
    } ref_t;

    // field codes by funct3, zero where funct3 is undefined
    localparam logic [6:0] br_codes [8] = '{`OP_BEQ, `OP_BNE, 7'd0, 7'd0,
                                            `OP_BLT, `OP_BGE, `OP_BLTU, `OP_BGEU};
    localparam logic [6:0] ld_codes [8] = '{`OP_LB, `OP_LH, `OP_LW, `OP_LD,
                                            `OP_LBU, `OP_LHU, `OP_LWU, 7'd0};
    localparam logic [6:0] st_codes [8] = '{`OP_SB, `OP_SH, `OP_SW, `OP_SD,
                                            7'd0, 7'd0, 7'd0, 7'd0};
    localparam logic [6:0] oi_codes [8] = '{`OP_ADDI, 7'd0, `OP_SLTI, `OP_SLTIU,
                                            `OP_XORI, 7'd0, `OP_ORI, `OP_ANDI};
    localparam logic [7:0] ro_codes [8] = '{`RO_ADD, `RO_SLL, `RO_SLT, `RO_SLTU,
                                            `RO_XOR, `RO_SRL, `RO_OR, `RO_AND};
    localparam logic [7:0] rw_codes [8] = '{`RO_ADDW, `RO_SLLW, 8'd0, 8'd0,
                                            8'd0, `RO_SRLW, 8'd0, 8'd0};
    localparam logic [6:0] majors [12] = '{7'h03, 7'h13, 7'h17, 7'h1b, 7'h23, 7'h33,
                                           7'h37, 7'h3b, 7'h63, 7'h67, 7'h6f, 7'h73};
    localparam int max_cycles = 3000; // ~9x the stimulus length

    logic                 clk;
    logic                 rst;
    logic [`XLEN-1:0]     gpr [`NUM_REGS];
    logic [`NUM_REGS-1:0] gpr_busy;
    logic                 valid_if_id;
    logic                 ready_if_id;
    logic [`XLEN-1:0]     pc_if_id;
    logic [`ILEN-1:0]     inst_if_id;
    logic [`XLEN-1:0]     src_a;
    logic [`XLEN-1:0]     src_b;
    logic [`XLEN-1:0]     imm;
    logic [`REG_AW-1:0]   rd;
    logic                 wen;
    logic [`OPCODE_W-1:0] opcode;
    logic                 valid_id_ex;
    logic [`XLEN-1:0]     pc_id_ex;
    logic [`ILEN-1:0]     inst_id_ex;

    logic [31:0]      lcg_state = 32'h31203f8c;
    logic             chk_armed = 1'b0; // set by stimulus, cleared by checker
    logic             exp_valid;
    logic [`XLEN-1:0] exp_pc;
    logic [`ILEN-1:0] exp_inst;
    int               checks = 0;
    int               errors = 0;
    int               num_tests = 0;
    int               test_checks;
    int               test_errors;
    int               cycles = 0;

    id_stage dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", max_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected decode of one word, straight from the rv64i/zicsr encodings
    function automatic ref_t ref_decode(input logic [31:0] w);
        ref_t       r;
        logic [6:0] f7;
        logic [2:0] f3;
        logic [6:0] base;
        logic       ebr;
        logic [1:0] up;
        logic [1:0] sh;
        logic [7:0] ro;
        logic [3:0] sys;
        logic       is_br;
        logic       is_st;
        f7 = w[31:25];
        f3 = w[14:12];
        base = '0;
        ebr = 1'b0;
        up = '0;
        sh = '0;
        ro = '0;
        sys = '0;
        case (w[6:0])
            7'h67: base = (f3 == 3'd0) ? `OP_JALR : 7'd0;
            7'h63: base = br_codes[f3];
            7'h03: base = ld_codes[f3];
            7'h23: base = st_codes[f3];
            7'h13: begin
                base = oi_codes[f3];
                if (f3 == 3'd1 && f7[6:1] == 6'b000000) sh = `SH_SLLI; // shamt[5] free
                if (f3 == 3'd5 && f7[6:1] == 6'b000000) sh = `SH_SRLI;
                if (f3 == 3'd5 && f7[6:1] == 6'b010000) sh = `SH_SRAI;
            end
            7'h1b: begin
                if (f3 == 3'd0) base = `OP_ADDIW;
                else if (f7 == 7'h00 && f3 == 3'd1) ro = `RO_SLLIW;
                else if (f7 == 7'h00 && f3 == 3'd5) ro = `RO_SRLIW;
                else if (f7 == 7'h20 && f3 == 3'd5) ro = `RO_SRAIW;
            end
            7'h33: begin
                if (f7 == 7'h00) ro = ro_codes[f3];
                else if (f7 == 7'h20 && f3 == 3'd0) ro = `RO_SUB; // mul/div fall through
                else if (f7 == 7'h20 && f3 == 3'd5) ro = `RO_SRA;
            end
            7'h3b: begin
                if (f7 == 7'h00) ro = rw_codes[f3];
                else if (f7 == 7'h20 && f3 == 3'd0) ro = `RO_SUBW;
                else if (f7 == 7'h20 && f3 == 3'd5) ro = `RO_SRAW;
            end
            7'h37: up = `UP_LUI;
            7'h17: up = `UP_AUIPC;
            7'h6f: up = `UP_JAL;
            7'h73: begin
                if (f3 == 3'd1) base = `OP_CSRRW;
                if (f3 == 3'd2) base = `OP_CSRRS;
                if (w == 32'h0000_0073) sys = `SYS_ECALL;
                if (w == 32'h3020_0073) sys = `SYS_MRET;
                if (w == 32'h0010_0073) ebr = 1'b1;
            end
            default: ;
        endcase
        r.opcode    = {sys, ro, sh, up, ebr, base}; // 23:20 19:12 11:10 9:8 7 6:0
        is_br       = base inside {[`OP_BEQ:`OP_BGEU]};
        is_st       = base inside {`OP_SB, `OP_SH, `OP_SW, `OP_SD};
        r.needs_rs1 = (|r.opcode) && up == 2'd0 && sys == 4'd0 && !ebr;
        r.needs_rs2 = is_br || is_st || (ro != 8'd0);
        r.wen       = (|r.opcode) && !is_br && !is_st && sys == 4'd0 && !ebr;
        if (up == `UP_LUI || up == `UP_AUIPC) r.imm = {{32{w[31]}}, w[31:12], 12'h000};
        else if (up == `UP_JAL) r.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        else if (is_st) r.imm = {{52{w[31]}}, w[31:25], w[11:7]};
        else r.imm = {{52{w[31]}}, w[31:20]}; // I immediate, also for undefined words
        return r;
    endfunction

    // one word from a kept major opcode, now and then a fully random word
    function automatic logic [31:0] rand_inst();
        logic [31:0] w;
        logic [31:0] pick;
        logic [3:0]  k;
        logic [1:0]  f;
        w    = lcg_next();
        pick = lcg_next();
        k    = 4'(pick[31:16] % 16'd12); // upper lcg bits
        f    = pick[11:10];
        if (pick[15:12] != 4'd0) begin
            w[6:0] = majors[k];
            if (f == 2'd0) w[31:25] = 7'h00; // base encodings
            if (f == 2'd1) w[31:25] = 7'h20; // sub/sra variants
            if (w[6:0] == 7'h73 && f == 2'd0) w = 32'h0000_0073;
            if (w[6:0] == 7'h73 && f == 2'd1) w = 32'h3020_0073;
            if (w[6:0] == 7'h73 && f == 2'd2) w = 32'h0010_0073;
        end
        return w;
    endfunction

    task automatic check_opcode(input string name, input logic [`OPCODE_W-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [`XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_inst(input string name, input logic [`ILEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input logic [`REG_AW-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // outputs settle after the capturing edge, sampled mid-cycle
    always @(negedge clk) begin : compare_outputs
        ref_t e;
        logic stall;
        if (chk_armed) begin
            e     = ref_decode(exp_inst);
            stall = (e.needs_rs1 && gpr_busy[exp_inst[19:15]])
                  || (e.needs_rs2 && gpr_busy[exp_inst[24:20]]); // x0 included
            check_opcode("opcode", opcode, e.opcode);
            check_bit("wen", wen, e.wen);
            check_index("rd", rd, exp_inst[11:7]);
            check_word("imm", imm, e.imm);
            check_word("src_a", src_a, gpr[exp_inst[19:15]]);
            check_word("src_b", src_b, gpr[exp_inst[24:20]]);
            check_bit("ready_if_id", ready_if_id, !stall);
            check_bit("valid_id_ex", valid_id_ex, exp_valid && !stall);
            check_word("pc_id_ex", pc_id_ex, stall ? 64'd0 : exp_pc);
            check_inst("inst_id_ex", inst_id_ex, stall ? 32'd0 : exp_inst);
            chk_armed = 1'b0;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2; // inputs change just after the edge
    endtask

    task automatic drive(input logic v, input logic [63:0] pc, input logic [31:0] w);
        valid_if_id = v;
        pc_if_id    = pc;
        inst_if_id  = w;
    endtask

    // expected content of the stage register, compared at the next negedge
    task automatic arm_check(input logic v, input logic [63:0] pc, input logic [31:0] w);
        exp_valid = v;
        exp_pc    = pc;
        exp_inst  = v ? w : 32'd0; // empty slot reads as zero
        chk_armed = 1'b1;
        wait (!chk_armed);
    endtask

    // one instruction alone in the stage with the given busy bits
    task automatic run_single(input logic [31:0] w, input logic [63:0] pc,
                              input logic [31:0] busy);
        drive(1'b1, pc, w);
        gpr_busy = busy;
        next_cycle();
        drive(1'b0, 64'd0, 32'd0);
        arm_check(1'b1, pc, w);
        next_cycle();
    endtask

    task automatic start_test();
        test_checks = checks;
        test_errors = errors;
    endtask

    task automatic finish_test(input string name);
        num_tests++;
        $display("test %-8s %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
    endtask

    initial begin : stimulus
        logic [31:0] w;
        logic [31:0] prev;
        logic [63:0] pc;
        logic [63:0] prev_pc;
        rst = 1'b1;
        gpr_busy = '0;
        drive(1'b0, 64'd0, 32'd0);
        for (int i = 0; i < `NUM_REGS; i++) gpr[i] = {lcg_next(), lcg_next()};
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;

        start_test();
        arm_check(1'b0, 64'd0, 32'd0); // still the reset contents
        finish_test("reset");

        start_test();
        next_cycle();
        prev    = rand_inst();
        prev_pc = {lcg_next(), lcg_next()};
        drive(1'b1, prev_pc, prev);
        next_cycle();
        for (int i = 1; i < 300; i++) begin
            w  = rand_inst();
            pc = {lcg_next(), lcg_next()};
            drive(1'b1, pc, w); // next one offered while the last is checked
            arm_check(1'b1, prev_pc, prev);
            next_cycle();
            prev    = w;
            prev_pc = pc;
        end
        drive(1'b0, 64'd0, 32'd0);
        arm_check(1'b1, prev_pc, prev);
        next_cycle();
        finish_test("random");

        start_test();
        next_cycle(); // let the bubble settle in
        w = {7'h00, 5'd6, 5'd5, 3'd0, 5'd3, 7'h33}; // add x3, x5, x6
        drive(1'b1, 64'h1000, w);
        gpr_busy = 32'd1 << 6; // rs2 pending
        next_cycle();
        drive(1'b1, 64'h1004, {12'h123, 5'd8, 3'd0, 5'd7, 7'h13}); // addi must wait
        arm_check(1'b1, 64'h1000, w);
        next_cycle();
        arm_check(1'b1, 64'h1000, w);
        next_cycle();
        gpr_busy = '0;
        arm_check(1'b1, 64'h1000, w); // released with its own pc
        next_cycle();
        drive(1'b0, 64'd0, 32'd0);
        arm_check(1'b1, 64'h1004, {12'h123, 5'd8, 3'd0, 5'd7, 7'h13});
        next_cycle();
        finish_test("stall");

        start_test();
        w = {20'habcde, 5'd1, 7'h37}; // lui, rs1 field busy
        run_single(w, 64'h2000, 32'd1 << w[19:15]);
        w = {20'h12345, 5'd1, 7'h6f}; // jal, rs1 field busy
        run_single(w, 64'h2004, 32'd1 << w[19:15]);
        w = {12'h7ff, 5'd2, 3'd0, 5'd4, 7'h13}; // addi, rs2 field busy
        run_single(w, 64'h2008, 32'd1 << w[24:20]);
        w = {7'h20, 5'd2, 5'd1, 3'd5, 5'd3, 7'h33}; // sra, rd field busy
        run_single(w, 64'h200c, 32'd1 << w[11:7]);
        finish_test("nostall");

        start_test();
        run_single(32'h0000_0000, 64'h3000, '1); // every register busy
        run_single(32'h0200_0033, 64'h3004, '1); // mul, not decoded
        run_single(32'hffff_ffff, 64'h3008, '1);
        run_single(32'h0000_2063, 64'h300c, '1); // branch funct3 hole
        run_single(32'h0000_7003, 64'h3010, '1); // load funct3 hole
        run_single(32'h1050_0073, 64'h3014, '1); // wfi
        gpr_busy = '0;
        finish_test("undef");

        $display("tests %0d, checks %0d, errors %0d", num_tests, checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: hw/id_stage.sv
// id_stage, instruction decode stage top level
`timescale 1ns/1ps
`include "rv_defines.svh"

module id_stage
    import rv_decode_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`XLEN-1:0]     gpr [`NUM_REGS],
    input  logic [`NUM_REGS-1:0] gpr_busy,
    input  logic                 valid_if_id,
    output logic                 ready_if_id,
    input  logic [`XLEN-1:0]     pc_if_id,
    input  logic [`ILEN-1:0]     inst_if_id,
    output logic [`XLEN-1:0]     src_a,
    output logic [`XLEN-1:0]     src_b,
    output logic [`XLEN-1:0]     imm,
    output logic [`REG_AW-1:0]   rd,
    output logic                 wen,
    output logic [`OPCODE_W-1:0] opcode,
    output logic                 valid_id_ex,
    output logic [`XLEN-1:0]     pc_id_ex,
    output logic [`ILEN-1:0]     inst_id_ex
);

    logic             reg_valid;
    logic [`XLEN-1:0] reg_pc;
    inst_word_u       inst;  // registered, zero when empty
    logic             hold;

    decode_if  dec_bus ();
    imm_bus_if imm_bus ();

    id_stage_reg u_reg (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .valid_if_id (valid_if_id),
        .pc_if_id    (pc_if_id),
        .inst_if_id  (inst_if_id),
        .reg_valid   (reg_valid),
        .reg_pc      (reg_pc),
        .inst        (inst)
    );

    inst_decoder u_dec (
        .inst (inst),
        .dec  (dec_bus)
    );

    imm_gen u_imm (
        .inst (inst),
        .imm  (imm_bus)
    );

    id_issue u_iss (
        .reg_valid   (reg_valid),
        .reg_pc      (reg_pc),
        .inst        (inst),
        .gpr         (gpr),
        .gpr_busy    (gpr_busy),
        .dec         (dec_bus),
        .imm         (imm_bus),
        .hold        (hold),
        .ready_if_id (ready_if_id),
        .src_a       (src_a),
        .src_b       (src_b),
        .imm_out     (imm),
        .rd          (rd),
        .wen         (wen),
        .opcode      (opcode),
        .valid_id_ex (valid_id_ex),
        .pc_id_ex    (pc_id_ex),
        .inst_id_ex  (inst_id_ex)
    );

endmodule

// File: hw/id_issue.sv
// id_issue, scoreboard stall, operand read, immediate select, output gating
`timescale 1ns/1ps
`include "rv_defines.svh"

module id_issue
    import rv_decode_pkg::*;
(
    input  logic                 reg_valid,
    input  logic [`XLEN-1:0]     reg_pc,
    input  inst_word_u           inst,
    input  logic [`XLEN-1:0]     gpr [`NUM_REGS],
    input  logic [`NUM_REGS-1:0] gpr_busy,   // pending writes
    decode_if.iss                dec,
    imm_bus_if.iss               imm,
    output logic                 hold,
    output logic                 ready_if_id,
    output logic [`XLEN-1:0]     src_a,
    output logic [`XLEN-1:0]     src_b,
    output logic [`XLEN-1:0]     imm_out,
    output logic [`REG_AW-1:0]   rd,
    output logic                 wen,
    output logic [`OPCODE_W-1:0] opcode,
    output logic                 valid_id_ex,
    output logic [`XLEN-1:0]     pc_id_ex,
    output logic [`ILEN-1:0]     inst_id_ex
);

    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic               stall;

    assign rs1 = inst.r_fmt.rs1;
    assign rs2 = inst.r_fmt.rs2;
    assign rd  = inst.r_fmt.rd;

    assign src_a = gpr[rs1]; // raw read, no bypass
    assign src_b = gpr[rs2];

    // x0 busy still stalls
    assign stall = (dec.needs_rs1 && gpr_busy[rs1])
                 || (dec.needs_rs2 && gpr_busy[rs2]);

    assign hold        = stall;
    assign ready_if_id = !stall;

    always_comb begin
        case (dec.imm_sel)
            `IMM_SEL_U: imm_out = imm.imm_u;
            `IMM_SEL_J: imm_out = imm.imm_j;
            `IMM_SEL_S: imm_out = imm.imm_s;
            default:    imm_out = imm.imm_i;
        endcase
    end

    // decode results stay visible during a stall
    assign wen    = dec.wen;
    assign opcode = dec.opcode;

    // bubble toward ex while stalled
    assign valid_id_ex = stall ? 1'b0 : reg_valid;
    assign pc_id_ex    = stall ? '0 : reg_pc;
    assign inst_id_ex  = stall ? '0 : inst;

    // nothing leaves the stage while upstream is refused
    always_comb begin
        a_issue_ready: assert (!valid_id_ex || ready_if_id);
    end

endmodule

// File: hw/imm_gen.sv
// imm_gen, I/U/J/S immediate extraction and sign extension
`timescale 1ns/1ps
`include "rv_defines.svh"

module imm_gen
    import rv_decode_pkg::*;
(
    input  inst_word_u inst,
    imm_bus_if.gen     imm
);

    logic sign; // instruction bit 31 in every format

    assign sign = inst.j_fmt.imm_20;

    assign imm.imm_i = {{(`XLEN-12){sign}}, inst.i_fmt.imm_11_0};
    assign imm.imm_u = {{(`XLEN-32){sign}}, inst.u_fmt.imm_31_12, 12'b0}; // low 12 clear
    assign imm.imm_s = {{(`XLEN-12){sign}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign imm.imm_j = {{(`XLEN-21){sign}},
                        inst.j_fmt.imm_20,
                        inst.j_fmt.imm_19_12,
                        inst.j_fmt.imm_11,
                        inst.j_fmt.imm_10_1,
                        1'b0}; // halfword aligned

endmodule

// File: hw/inst_decoder.sv
// inst_decoder, RV64I/Zicsr opcode word decode and control flags
`timescale 1ns/1ps
`include "rv_defines.svh"

module inst_decoder
    import rv_decode_pkg::*;
(
    input  inst_word_u inst,
    decode_if.dec      dec
);

    // major opcodes
    localparam logic [6:0] MJ_LOAD     = 7'b0000011;
    localparam logic [6:0] MJ_OP_IMM   = 7'b0010011;
    localparam logic [6:0] MJ_AUIPC    = 7'b0010111;
    localparam logic [6:0] MJ_OP_IMM32 = 7'b0011011;
    localparam logic [6:0] MJ_STORE    = 7'b0100011;
    localparam logic [6:0] MJ_OP       = 7'b0110011;
    localparam logic [6:0] MJ_LUI      = 7'b0110111;
    localparam logic [6:0] MJ_OP32     = 7'b0111011;
    localparam logic [6:0] MJ_BRANCH   = 7'b1100011;
    localparam logic [6:0] MJ_JALR     = 7'b1100111;
    localparam logic [6:0] MJ_JAL      = 7'b1101111;
    localparam logic [6:0] MJ_SYSTEM   = 7'b1110011;

    logic [`ILEN-1:0]     word;
    logic [6:0]           major;
    logic [2:0]           f3;
    logic [6:0]           f7;
    logic [`OPCODE_W-1:0] op;
    logic [6:0]           base;
    logic                 is_branch;
    logic                 is_store;

    assign word  = inst;
    assign major = inst.r_fmt.opcode;
    assign f3    = inst.r_fmt.funct3;
    assign f7    = inst.r_fmt.funct7;

    always_comb begin
        op = '0; // undefined words leave every field zero
        case (major)
            MJ_JALR: if (f3 == 3'b000) op[`OPC_BASE] = `OP_JALR;
            MJ_BRANCH: begin
                case (f3)
                    3'b000:  op[`OPC_BASE] = `OP_BEQ;
                    3'b001:  op[`OPC_BASE] = `OP_BNE;
                    3'b100:  op[`OPC_BASE] = `OP_BLT;
                    3'b101:  op[`OPC_BASE] = `OP_BGE;
                    3'b110:  op[`OPC_BASE] = `OP_BLTU;
                    3'b111:  op[`OPC_BASE] = `OP_BGEU;
                    default: ;
                endcase
            end
            MJ_LOAD: begin
                case (f3)
                    3'b000:  op[`OPC_BASE] = `OP_LB;
                    3'b001:  op[`OPC_BASE] = `OP_LH;
                    3'b010:  op[`OPC_BASE] = `OP_LW;
                    3'b011:  op[`OPC_BASE] = `OP_LD;
                    3'b100:  op[`OPC_BASE] = `OP_LBU;
                    3'b101:  op[`OPC_BASE] = `OP_LHU;
                    3'b110:  op[`OPC_BASE] = `OP_LWU;
                    default: ;
                endcase
            end
            MJ_STORE: begin
                case (f3)
                    3'b000:  op[`OPC_BASE] = `OP_SB;
                    3'b001:  op[`OPC_BASE] = `OP_SH;
                    3'b010:  op[`OPC_BASE] = `OP_SW;
                    3'b011:  op[`OPC_BASE] = `OP_SD;
                    default: ;
                endcase
            end
            MJ_OP_IMM: begin
                case (f3)
                    3'b000:  op[`OPC_BASE] = `OP_ADDI;
                    3'b010:  op[`OPC_BASE] = `OP_SLTI;
                    3'b011:  op[`OPC_BASE] = `OP_SLTIU;
                    3'b100:  op[`OPC_BASE] = `OP_XORI;
                    3'b110:  op[`OPC_BASE] = `OP_ORI;
                    3'b111:  op[`OPC_BASE] = `OP_ANDI;
                    // rv64 shamt is 6 bits, funct6 above it
                    3'b001:  if (f7[6:1] == 6'b000000) op[`OPC_SHIFT] = `SH_SLLI;
                    3'b101: begin
                        if (f7[6:1] == 6'b000000) op[`OPC_SHIFT] = `SH_SRLI;
                        else if (f7[6:1] == 6'b010000) op[`OPC_SHIFT] = `SH_SRAI;
                    end
                    default: ;
                endcase
            end
            MJ_OP_IMM32: begin
                if (f3 == 3'b000) begin
                    op[`OPC_BASE] = `OP_ADDIW; // any imm
                end else begin
                    case ({f7, f3})
                        10'b0000000_001: op[`OPC_REGOP] = `RO_SLLIW;
                        10'b0000000_101: op[`OPC_REGOP] = `RO_SRLIW;
                        10'b0100000_101: op[`OPC_REGOP] = `RO_SRAIW;
                        default:         ;
                    endcase
                end
            end
            MJ_OP: begin
                case ({f7, f3})
                    10'b0000000_000: op[`OPC_REGOP] = `RO_ADD;
                    10'b0100000_000: op[`OPC_REGOP] = `RO_SUB;
                    10'b0000000_001: op[`OPC_REGOP] = `RO_SLL;
                    10'b0000000_010: op[`OPC_REGOP] = `RO_SLT;
                    10'b0000000_011: op[`OPC_REGOP] = `RO_SLTU;
                    10'b0000000_100: op[`OPC_REGOP] = `RO_XOR;
                    10'b0000000_101: op[`OPC_REGOP] = `RO_SRL;
                    10'b0100000_101: op[`OPC_REGOP] = `RO_SRA;
                    10'b0000000_110: op[`OPC_REGOP] = `RO_OR;
                    10'b0000000_111: op[`OPC_REGOP] = `RO_AND;
                    default:         ; // M extension not decoded
                endcase
            end
            MJ_OP32: begin
                case ({f7, f3})
                    10'b0000000_000: op[`OPC_REGOP] = `RO_ADDW;
                    10'b0100000_000: op[`OPC_REGOP] = `RO_SUBW;
                    10'b0000000_001: op[`OPC_REGOP] = `RO_SLLW;
                    10'b0000000_101: op[`OPC_REGOP] = `RO_SRLW;
                    10'b0100000_101: op[`OPC_REGOP] = `RO_SRAW;
                    default:         ;
                endcase
            end
            MJ_LUI:   op[`OPC_UPPER] = `UP_LUI;
            MJ_AUIPC: op[`OPC_UPPER] = `UP_AUIPC;
            MJ_JAL:   op[`OPC_UPPER] = `UP_JAL;
            MJ_SYSTEM: begin
                case (f3)
                    3'b001:  op[`OPC_BASE] = `OP_CSRRW;
                    3'b010:  op[`OPC_BASE] = `OP_CSRRS;
                    3'b000: begin
                        // privileged ops match the whole word
                        if (word == 32'h0000_0073) op[`OPC_SYS] = `SYS_ECALL;
                        else if (word == 32'h3020_0073) op[`OPC_SYS] = `SYS_MRET;
                        else if (word == 32'h0010_0073) op[`OPC_EBREAK] = 1'b1;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    assign base      = op[`OPC_BASE];
    assign is_branch = (base >= `OP_BEQ) && (base <= `OP_BGEU);
    assign is_store  = ((base >= `OP_SB) && (base <= `OP_SW)) || (base == `OP_SD);

    assign dec.opcode    = op;
    // upper, system and ebreak fields read no register
    assign dec.needs_rs1 = (|base) || (|op[`OPC_SHIFT]) || (|op[`OPC_REGOP]);
    assign dec.needs_rs2 = is_branch || is_store || (|op[`OPC_REGOP]);
    assign dec.wen       = ((|base) && !is_branch && !is_store)
                         || (|op[`OPC_UPPER]) || (|op[`OPC_SHIFT]) || (|op[`OPC_REGOP]);

    always_comb begin
        if (op[`OPC_UPPER] == `UP_JAL) dec.imm_sel = `IMM_SEL_J;
        else if (|op[`OPC_UPPER])      dec.imm_sel = `IMM_SEL_U; // lui, auipc
        else if (is_store)             dec.imm_sel = `IMM_SEL_S;
        else                           dec.imm_sel = `IMM_SEL_I;
    end

    // the opcode word names one instruction at most
    always_comb begin
        a_one_field: assert ($onehot0({|base, op[`OPC_EBREAK], |op[`OPC_UPPER],
                                       |op[`OPC_SHIFT], |op[`OPC_REGOP], |op[`OPC_SYS]}));
    end

endmodule

// File: hw/id_stage_reg.sv
// id_stage_reg, decode stage pipeline register with hold
`timescale 1ns/1ps
`include "rv_defines.svh"

module id_stage_reg
    import rv_decode_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              hold,        // scoreboard stall
    input  logic              valid_if_id,
    input  logic [`XLEN-1:0]  pc_if_id,
    input  logic [`ILEN-1:0]  inst_if_id,
    output logic              reg_valid,
    output logic [`XLEN-1:0]  reg_pc,
    output inst_word_u        inst         // zero when slot empty
);

    logic [`ILEN-1:0] inst_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            reg_valid <= 1'b0;
            reg_pc    <= '0;
            inst_q    <= '0;
        end else if (!hold) begin // keep contents while stalled
            reg_valid <= valid_if_id;
            reg_pc    <= pc_if_id;
            inst_q    <= inst_if_id;
        end
    end

    assign inst = reg_valid ? inst_q : '0; // bubble decodes to nothing

    // a stalled instruction must not be overwritten
    a_hold_keeps: assert property (
        @(posedge clk) disable iff (rst)
        hold |=> ($stable(reg_pc) && $stable(inst_q))
    );

endmodule

// File: hw/imm_bus_if.sv
// imm_bus_if interface, sign-extended immediates from imm_gen
`timescale 1ns/1ps
`include "rv_defines.svh"

interface imm_bus_if;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] imm_s;

    modport gen (
        output imm_i, imm_u, imm_j, imm_s
    );

    modport iss (
        input imm_i, imm_u, imm_j, imm_s
    );
endinterface

// File: hw/decode_if.sv
// decode_if interface, decoder results toward the issue unit
`timescale 1ns/1ps
`include "rv_defines.svh"

interface decode_if;
    logic [`OPCODE_W-1:0] opcode; // one-hot-field opcode word
    logic                 wen;    // rd write enable
    logic                 needs_rs1;
    logic                 needs_rs2;
    logic [1:0]           imm_sel; // IMM_SEL_* code

    modport dec (
        output opcode, wen, needs_rs1, needs_rs2, imm_sel
    );

    modport iss (
        input opcode, wen, needs_rs1, needs_rs2, imm_sel
    );
endinterface

// File: hw/rv_decode_pkg.sv
// instruction format structs and the instruction word union
`include "rv_defines.svh"

package rv_decode_pkg;

    typedef struct packed {
        logic [6:0]         funct7;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode; // major opcode
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]        imm_11_0;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]         imm_11_5;
        logic [`REG_AW-1:0] rs2;
        logic [`REG_AW-1:0] rs1;
        logic [2:0]         funct3;
        logic [4:0]         imm_4_0;
        logic [6:0]         opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]        imm_31_12;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } u_fmt_t;

    typedef struct packed {
        logic               imm_20;
        logic [9:0]         imm_10_1;
        logic               imm_11;
        logic [7:0]         imm_19_12;
        logic [`REG_AW-1:0] rd;
        logic [6:0]         opcode;
    } j_fmt_t;

    // one 32-bit word, five views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_word_u;

endpackage

// File: hw/rv_defines.svh
// widths, opcode word field positions, field codes and immediate select codes
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

`define XLEN      64 // data and pc width
`define ILEN      32 // instruction width
`define REG_AW    5  // register index width
`define NUM_REGS  32
`define OPCODE_W  24 // decoded opcode word

// opcode word field ranges
`define OPC_BASE   6:0
`define OPC_EBREAK 7
`define OPC_UPPER  9:8   // lui/auipc/jal
`define OPC_SHIFT  11:10 // slli/srli/srai
`define OPC_REGOP  19:12
`define OPC_SYS    23:20 // ecall/mret

// base field codes
`define OP_JALR   7'd4
`define OP_BEQ    7'd5
`define OP_BNE    7'd6
`define OP_BLT    7'd7
`define OP_BGE    7'd8
`define OP_BLTU   7'd9
`define OP_BGEU   7'd10
`define OP_LB     7'd11
`define OP_LH     7'd12
`define OP_LW     7'd13
`define OP_LBU    7'd14
`define OP_LHU    7'd15
`define OP_SB     7'd16
`define OP_SH     7'd17
`define OP_SW     7'd18
`define OP_ADDI   7'd19
`define OP_SLTI   7'd20
`define OP_SLTIU  7'd21
`define OP_XORI   7'd22
`define OP_ORI    7'd23
`define OP_ANDI   7'd24
`define OP_LWU    7'd41
`define OP_LD     7'd42
`define OP_SD     7'd43
`define OP_ADDIW  7'd47
`define OP_CSRRW  7'd49
`define OP_CSRRS  7'd50

// upper/jal field codes
`define UP_LUI    2'd1
`define UP_AUIPC  2'd2
`define UP_JAL    2'd3

// shift-immediate field codes
`define SH_SLLI   2'd1
`define SH_SRLI   2'd2
`define SH_SRAI   2'd3

// register-op field codes
`define RO_ADD    8'h04
`define RO_SUB    8'h05
`define RO_SLL    8'h06
`define RO_SLT    8'h07
`define RO_SLTU   8'h08
`define RO_XOR    8'h09
`define RO_SRL    8'h10
`define RO_SRA    8'h11
`define RO_OR     8'h12
`define RO_AND    8'h13
`define RO_SLLIW  8'h14
`define RO_SRLIW  8'h15
`define RO_SRAIW  8'h16
`define RO_ADDW   8'h17
`define RO_SUBW   8'h18
`define RO_SLLW   8'h19
`define RO_SRLW   8'h1a
`define RO_SRAW   8'h1b

// system field codes
`define SYS_ECALL 4'd2
`define SYS_MRET  4'd5

// immediate select
`define IMM_SEL_I 2'd0
`define IMM_SEL_U 2'd1
`define IMM_SEL_J 2'd2
`define IMM_SEL_S 2'd3

`endif
